//--- design/spi_cfg_defs.svh
// network config register map
// byte addresses on the local config bus, the id constant
// and the position of the read flag in the SPI address byte

`ifndef SPI_CFG_DEFS_SVH
`define SPI_CFG_DEFS_SVH

// MAC address bytes, MAC0 is the most significant
`define CFG_ADDR_MAC0 8'h00
`define CFG_ADDR_MAC1 8'h01
`define CFG_ADDR_MAC2 8'h02
`define CFG_ADDR_MAC3 8'h03
`define CFG_ADDR_MAC4 8'h04
`define CFG_ADDR_MAC5 8'h05

// IP address bytes, IP0 is the most significant
`define CFG_ADDR_IP0 8'h06
`define CFG_ADDR_IP1 8'h07
`define CFG_ADDR_IP2 8'h08
`define CFG_ADDR_IP3 8'h09

// read-only registers
`define CFG_ADDR_ID 8'h0A
`define CFG_ADDR_WCNT 8'h0B

// offsets at or above this read as zero
`define CFG_NUM_REGS 8'h0C

// fixed identification byte
`define CFG_ID_VALUE 8'hA5

// address bit that marks a read transfer
`define CFG_READ_BIT 7

`endif

//--- design/spi_cfg_pkg.sv
// shared types for the SPI network config block
// config bus bundle, opcode and register offset

`include "spi_cfg_defs.svh"

package spi_cfg_pkg;

	// local config bus from the SPI gate to the register file
	// w and r are single-cycle strobes
	// a and d are levels held by the gate shift register
	typedef struct packed {
		// write strobe at end of transfer
		logic w;
		// read strobe after the address byte
		logic r;
		// address byte including the read flag
		logic [7:0] a;
		// data byte, second byte of the transfer
		logic [7:0] d;
	} cfg_bus_t;

	// operation carried in the top address bit
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ = 1'b1
	} cfg_op_e;

	// register offset, address with the read flag stripped
	typedef logic [`CFG_READ_BIT-1:0] cfg_reg_t;

endpackage

//--- design/spi_gate.sv
// SPI slave to local config bus bridge
// oversamples sclk, csb and mosi in the config_clk domain and turns each
// 16-bit transfer (address then data) into read and write strobes
// read data goes back on miso during the second byte

module spi_gate import spi_cfg_pkg::*; (
	input logic config_clk,
	input logic rst,
	// SPI pins, sclk idles high
	input logic sclk,
	input logic csb,
	input logic mosi,
	output logic miso,
	// read data from the register file
	input logic [7:0] rd_data,
	// config bus out
	output cfg_bus_t cfg,
	// registered pin states for bench debug
	output logic [3:0] spi_pins_debug
);

	// pin sync stage
	logic din;
	logic csb_d1;
	logic sclk_d1;
	// one more stage for edge detection
	logic csb_d2;
	logic sclk_d2;

	// {address, data} shifted in MSB first
	logic [15:0] sr;
	logic [4:0] bit_cnt;
	// set once the address byte has moved to the upper half
	logic halfway;

	// transmit shift register for miso
	logic [7:0] sr_tx;

	// strobes and their delayed copies
	logic cfg_w_q;
	logic cfg_r_q;
	logic cfg_r_q1;
	logic active_edge;
	logic active_edge1;
	logic active_edge2;

	// sclk falling edge while selected
	assign active_edge = ~csb_d1 & ~sclk_d1 & sclk_d2;

	always_ff @(posedge config_clk) begin
		if (rst) begin
			din <= 1'b0;
			// idle levels so no false csb edge comes out of reset
			csb_d1 <= 1'b1;
			csb_d2 <= 1'b1;
			sclk_d1 <= 1'b1;
			sclk_d2 <= 1'b1;
			sr <= 16'h0000;
			bit_cnt <= 5'd0;
			halfway <= 1'b0;
			sr_tx <= 8'h00;
			cfg_w_q <= 1'b0;
			cfg_r_q <= 1'b0;
			cfg_r_q1 <= 1'b0;
			active_edge1 <= 1'b0;
			active_edge2 <= 1'b0;
		end else begin
			// first register on the pins
			din <= mosi;
			csb_d1 <= csb;
			sclk_d1 <= sclk;
			// history for edges
			csb_d2 <= csb_d1;
			sclk_d2 <= sclk_d1;

			// take mosi on the active edge
			if (active_edge) begin
				sr <= {sr[14:0], din};
				halfway <= |bit_cnt[4:3];
			end

			// bit counter, falling csb restarts the transfer
			if (csb_d2 & ~csb_d1) begin
				bit_cnt <= 5'd0;
			end else if (active_edge) begin
				bit_cnt <= bit_cnt + 5'd1;
			end

			// delay the edge so miso moves after the master is done sampling
			active_edge1 <= active_edge;
			active_edge2 <= active_edge1;

			// read strobe on the eighth bit, address sits in the low byte
			cfg_r_q <= active_edge & (bit_cnt == 5'd7);
			cfg_r_q1 <= cfg_r_q;

			// load has priority over the delayed shift of the eighth edge
			if (cfg_r_q1) begin
				sr_tx <= rd_data;
			end else if (active_edge2) begin
				sr_tx <= {sr_tx[6:0], 1'b0};
			end

			// write strobe on rising csb
			cfg_w_q <= csb_d1 & ~csb_d2;
		end
	end

	// address moves to the high byte after the ninth bit
	assign cfg.w = cfg_w_q;
	assign cfg.r = cfg_r_q;
	assign cfg.a = halfway ? sr[15:8] : sr[7:0];
	assign cfg.d = sr[7:0];

	// MSB first, about three cycles after the sclk fall
	assign miso = sr_tx[7];

	assign spi_pins_debug = {miso, din, sclk_d1, csb_d1};

endmodule

//--- design/netcfg_regs.sv
// network config register file
// holds the MAC and IP address bytes written over the config bus,
// a fixed id and a count of accepted writes
// read data is a combinational mux on the bus address

`include "spi_cfg_defs.svh"

module netcfg_regs import spi_cfg_pkg::*; (
	input logic config_clk,
	input logic rst,
	// local config bus from the SPI gate
	input cfg_bus_t cfg,
	// byte at the current address
	output logic [7:0] rd_data,
	// MAC0 in bits 47:40
	output logic [47:0] mac_addr,
	// IP0 in bits 31:24
	output logic [31:0] ip_addr,
	// one cycle pulse after an accepted write
	output logic cfg_update
);

	// decoded address
	cfg_op_e op;
	cfg_reg_t reg_off;
	logic [7:0] reg_addr;
	logic in_range;

	// byte lane selects, bit 5 is MAC0 and bit 3 is IP0
	logic [5:0] mac_sel;
	logic [3:0] ip_sel;
	logic wr_en;

	// storage
	logic [47:0] mac_q;
	logic [31:0] ip_q;
	logic [7:0] wcnt;
	logic update_q;

	// split the address byte into opcode and offset
	assign op = cfg_op_e'(cfg.a[`CFG_READ_BIT]);
	assign reg_off = cfg.a[`CFG_READ_BIT-1:0];
	// offset compared against the map with the read flag cleared
	assign reg_addr = {1'b0, reg_off};
	assign in_range = reg_addr < `CFG_NUM_REGS;

	// address decode and read mux
	always_comb begin
		mac_sel = 6'b000000;
		ip_sel = 4'b0000;
		rd_data = 8'h00;
		if (in_range) begin
			case (reg_addr)
				`CFG_ADDR_MAC0: begin
					mac_sel = 6'b100000;
					rd_data = mac_q[47:40];
				end
				`CFG_ADDR_MAC1: begin
					mac_sel = 6'b010000;
					rd_data = mac_q[39:32];
				end
				`CFG_ADDR_MAC2: begin
					mac_sel = 6'b001000;
					rd_data = mac_q[31:24];
				end
				`CFG_ADDR_MAC3: begin
					mac_sel = 6'b000100;
					rd_data = mac_q[23:16];
				end
				`CFG_ADDR_MAC4: begin
					mac_sel = 6'b000010;
					rd_data = mac_q[15:8];
				end
				`CFG_ADDR_MAC5: begin
					mac_sel = 6'b000001;
					rd_data = mac_q[7:0];
				end
				`CFG_ADDR_IP0: begin
					ip_sel = 4'b1000;
					rd_data = ip_q[31:24];
				end
				`CFG_ADDR_IP1: begin
					ip_sel = 4'b0100;
					rd_data = ip_q[23:16];
				end
				`CFG_ADDR_IP2: begin
					ip_sel = 4'b0010;
					rd_data = ip_q[15:8];
				end
				`CFG_ADDR_IP3: begin
					ip_sel = 4'b0001;
					rd_data = ip_q[7:0];
				end
				`CFG_ADDR_ID: rd_data = `CFG_ID_VALUE;
				`CFG_ADDR_WCNT: rd_data = wcnt;
				default: rd_data = 8'h00;
			endcase
		end
	end

	// only MAC and IP bytes accept writes
	// id, count and unmapped offsets drop them uncounted
	assign wr_en = cfg.w & (op == OP_WRITE) & (|{mac_sel, ip_sel});

	always_ff @(posedge config_clk) begin
		if (rst) begin
			mac_q <= 48'h0;
			ip_q <= 32'h0;
			wcnt <= 8'h00;
			update_q <= 1'b0;
		end else begin
			if (wr_en) begin
				for (int i = 0; i < 6; i++) begin
					if (mac_sel[i]) begin
						mac_q[8*i +: 8] <= cfg.d;
					end
				end
				for (int i = 0; i < 4; i++) begin
					if (ip_sel[i]) begin
						ip_q[8*i +: 8] <= cfg.d;
					end
				end
				// wraps at 256
				wcnt <= wcnt + 8'd1;
			end
			// lines up with the new register values
			update_q <= wr_en;
		end
	end

	assign mac_addr = mac_q;
	assign ip_addr = ip_q;
	assign cfg_update = update_q;

endmodule

//--- design/spi_cfg_top.sv
// SPI network config top level
// SPI gate feeding the MAC and IP register file over the local config bus
// pins in, addresses and update pulse out

module spi_cfg_top import spi_cfg_pkg::*; (
	input logic config_clk,
	input logic rst,
	// SPI pins from the microcontroller
	input logic sclk,
	input logic csb,
	input logic mosi,
	output logic miso,
	// configured addresses
	output logic [47:0] mac_addr,
	output logic [31:0] ip_addr,
	// pulses when either address changes
	output logic cfg_update,
	// registered pin states
	output logic [3:0] spi_pins_debug
);

	// config bus between gate and register file
	cfg_bus_t cfg;
	// read data back to the gate
	logic [7:0] rd_data;

	spi_gate u_spi_gate (
		.config_clk(config_clk),
		.rst(rst),
		.sclk(sclk),
		.csb(csb),
		.mosi(mosi),
		.miso(miso),
		.rd_data(rd_data),
		.cfg(cfg),
		.spi_pins_debug(spi_pins_debug)
	);

	netcfg_regs u_netcfg_regs (
		.config_clk(config_clk),
		.rst(rst),
		.cfg(cfg),
		.rd_data(rd_data),
		.mac_addr(mac_addr),
		.ip_addr(ip_addr),
		.cfg_update(cfg_update)
	);

endmodule

//--- verification/spi_cfg_chk.sv
// bound checker for the network config register file
// watches the config bus strobes, the update pulse and the write counter

module spi_cfg_chk import spi_cfg_pkg::*; (
	input logic config_clk,
	input logic rst,
	input cfg_bus_t cfg,
	input cfg_op_e op,
	input logic [7:0] wcnt,
	input logic cfg_update
);

	// number of assertion failures so far
	int err_count = 0;

	// read strobe comes mid transfer, write strobe at the end
	a_no_wr_rd: assert property (@(posedge config_clk) disable iff (rst)
		!(cfg.w && cfg.r))
	else begin
		$error("write and read strobes high in the same cycle");
		err_count++;
	end

	// write strobe lasts one cycle
	a_w_single: assert property (@(posedge config_clk) disable iff (rst)
		cfg.w |=> !cfg.w)
	else begin
		$error("write strobe high two cycles in a row");
		err_count++;
	end

	// update pulse only after a write strobe carrying the write opcode
	a_update_src: assert property (@(posedge config_clk) disable iff (rst)
		cfg_update |-> $past(cfg.w && op == OP_WRITE))
	else begin
		$error("cfg_update without a preceding write strobe");
		err_count++;
	end

	// counter steps by one together with the update pulse
	// the first cycle after reset is skipped, the count drops to zero there
	a_wcnt_step: assert property (@(posedge config_clk) disable iff (rst)
		(!$past(rst) && wcnt != $past(wcnt)) |-> (cfg_update && wcnt == $past(wcnt) + 8'd1))
	else begin
		$error("write counter changed outside a single step on cfg_update");
		err_count++;
	end

endmodule

bind netcfg_regs spi_cfg_chk u_chk (
	.config_clk(config_clk),
	.rst(rst),
	.cfg(cfg),
	.op(op),
	.wcnt(wcnt),
	.cfg_update(cfg_update)
);

//--- verification/spi_cfg_tb.sv
// testbench for the SPI network config block
// runs SPI transfers from a table and checks the read byte on miso,
// the update pulse and the MAC and IP outputs against a register model

`include "spi_cfg_defs.svh"

module spi_cfg_tb;

	// one transfer with its expected results
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
		logic [7:0] exp_rd;
		logic rd_dc;
		logic exp_upd;
		logic reset_first;
		logic [47:0] exp_mac;
		logic [31:0] exp_ip;
	} row_t;

	// read flag as set in the address byte
	localparam logic [7:0] READ_FLAG = 8'h01 << `CFG_READ_BIT;

	logic config_clk;
	logic rst;
	logic sclk;
	logic csb;
	logic mosi;
	logic miso;
	logic [47:0] mac_addr;
	logic [31:0] ip_addr;
	logic cfg_update;
	logic [3:0] spi_pins_debug;

	// transaction table and labels
	row_t rows[$];
	string labels[$];
	// register model, MAC0..MAC5 then IP0..IP3
	logic [7:0] model_regs [0:9];
	logic [7:0] model_wcnt;
	logic [31:0] lcg_state;
	int pass_count;
	int fail_count;
	int chk_errs;

	spi_cfg_top UUT (
		.config_clk(config_clk),
		.rst(rst),
		.sclk(sclk),
		.csb(csb),
		.mosi(mosi),
		.miso(miso),
		.mac_addr(mac_addr),
		.ip_addr(ip_addr),
		.cfg_update(cfg_update),
		.spi_pins_debug(spi_pins_debug)
	);

	always #20 config_clk = ~config_clk;

	function automatic logic [7:0] next_rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// append a row, expected values come from the model before and after
	task automatic add_row(input logic [7:0] addr, input logic [7:0] data,
			input logic reset_first, input string label);
		row_t row;
		logic [7:0] off;
		if (reset_first) begin
			for (int i = 0; i < 10; i++) begin
				model_regs[i] = 8'h00;
			end
			model_wcnt = 8'h00;
		end
		off = {1'b0, addr[6:0]};
		row.addr = addr;
		row.data = data;
		row.reset_first = reset_first;
		// miso byte only matters on reads
		row.rd_dc = ~addr[`CFG_READ_BIT];
		if (off < `CFG_ADDR_ID)
			row.exp_rd = model_regs[off];
		else if (off == `CFG_ADDR_ID)
			row.exp_rd = `CFG_ID_VALUE;
		else if (off == `CFG_ADDR_WCNT)
			row.exp_rd = model_wcnt;
		else
			row.exp_rd = 8'h00;
		// MAC and IP bytes sit below the id and are the only writable ones
		row.exp_upd = ~addr[`CFG_READ_BIT] && (off < `CFG_ADDR_ID);
		if (row.exp_upd) begin
			model_regs[off] = data;
			model_wcnt = model_wcnt + 8'd1;
		end
		row.exp_mac = {model_regs[0], model_regs[1], model_regs[2],
			model_regs[3], model_regs[4], model_regs[5]};
		row.exp_ip = {model_regs[6], model_regs[7], model_regs[8], model_regs[9]};
		rows.push_back(row);
		labels.push_back(label);
	endtask

	task automatic apply_reset();
		@(negedge config_clk);
		rst = 1'b1;
		repeat (2) @(negedge config_clk);
		rst = 1'b0;
	endtask

	// one sclk half period
	task automatic hold_level();
		repeat (8) @(negedge config_clk);
	endtask

	// registered pin copy after the pins have held for a half period
	task automatic check_pins(input string label, inout logic pins_ok);
		logic [3:0] exp_pins;
		exp_pins = {miso, mosi, sclk, csb};
		assert (spi_pins_debug == exp_pins) else begin
			$display("Mismatch spi_pins_debug in %s: expected %h actual %h",
				label, exp_pins, spi_pins_debug);
			pins_ok = 1'b0;
		end
	endtask

	// one 16-bit transfer, address then data, MSB first
	task automatic spi_xfer(input logic [7:0] addr, input logic [7:0] data,
			input string label, output logic [7:0] rx, output logic pins_ok);
		logic [15:0] word;
		word = {addr, data};
		rx = 8'h00;
		pins_ok = 1'b1;
		@(negedge config_clk);
		csb = 1'b0;
		mosi = word[15];
		hold_level();
		for (int i = 0; i < 16; i++) begin
			// slave takes the bit already on mosi at this fall
			sclk = 1'b0;
			hold_level();
			check_pins(label, pins_ok);
			// read byte is on miso from the eighth fall on
			if (i >= 7 && i < 15)
				rx = {rx[6:0], miso};
			sclk = 1'b1;
			if (i < 15)
				mosi = word[14-i];
			hold_level();
			check_pins(label, pins_ok);
		end
		csb = 1'b1;
	endtask

	// stops at the first cfg_update or after 40 cycles
	task automatic watch_update(output logic seen);
		seen = 1'b0;
		for (int n = 0; n < 40 && !seen; n++) begin
			@(negedge config_clk);
			seen = cfg_update;
		end
	endtask

	initial begin : main
		row_t row;
		logic [7:0] rx;
		logic seen;
		logic row_ok;
		logic pins_ok;
		config_clk = 1'b0;
		rst = 1'b1;
		sclk = 1'b1;
		csb = 1'b1;
		mosi = 1'b0;
		lcg_state = 32'h8afd;
		pass_count = 0;
		fail_count = 0;
		model_wcnt = 8'h00;
		for (int i = 0; i < 10; i++) begin
			model_regs[i] = 8'h00;
		end

		for (int i = 0; i < 6; i++)
			add_row(8'(`CFG_ADDR_MAC0 + i), next_rand_byte(), 1'b0, $sformatf("write mac%0d", i));
		for (int i = 0; i < 4; i++)
			add_row(8'(`CFG_ADDR_IP0 + i), next_rand_byte(), 1'b0, $sformatf("write ip%0d", i));
		for (int i = 0; i < 10; i++)
			add_row(8'(`CFG_ADDR_MAC0 + i) | READ_FLAG, 8'h00, 1'b0, $sformatf("read reg %0d", i));
		add_row(`CFG_ADDR_ID | READ_FLAG, 8'h00, 1'b0, "read id");
		add_row(8'h30 | READ_FLAG, 8'h00, 1'b0, "read unmapped");
		add_row(`CFG_ADDR_ID, 8'h5c, 1'b0, "write id dropped");
		add_row(`CFG_ADDR_WCNT, 8'h33, 1'b0, "write count dropped");
		add_row(`CFG_ADDR_ID | READ_FLAG, 8'h00, 1'b0, "read id again");
		add_row(`CFG_ADDR_WCNT | READ_FLAG, 8'h00, 1'b0, "read count");
		add_row(`CFG_ADDR_WCNT | READ_FLAG, 8'h00, 1'b1, "reset then read count");
		add_row(`CFG_ADDR_MAC0 | READ_FLAG, 8'h00, 1'b0, "read mac0 after reset");

		apply_reset();
		for (int t = 0; t < rows.size(); t++) begin
			row = rows[t];
			row_ok = 1'b1;
			if (row.reset_first)
				apply_reset();
			spi_xfer(row.addr, row.data, labels[t], rx, pins_ok);
			if (!pins_ok)
				row_ok = 1'b0;
			watch_update(seen);
			if (row.exp_upd) begin
				assert (seen) else begin
					$display("%s: no cfg_update after write", labels[t]);
					row_ok = 1'b0;
				end
			end else begin
				assert (!seen) else begin
					$display("%s: cfg_update pulsed but no write was due", labels[t]);
					row_ok = 1'b0;
				end
			end
			if (!row.rd_dc) begin
				assert (rx == row.exp_rd) else begin
					$display("Mismatch miso in %s: expected %h actual %h",
						labels[t], row.exp_rd, rx);
					row_ok = 1'b0;
				end
			end
			assert (mac_addr == row.exp_mac) else begin
				$display("Mismatch mac_addr in %s: expected %h actual %h",
					labels[t], row.exp_mac, mac_addr);
				row_ok = 1'b0;
			end
			assert (ip_addr == row.exp_ip) else begin
				$display("Mismatch ip_addr in %s: expected %h actual %h",
					labels[t], row.exp_ip, ip_addr);
				row_ok = 1'b0;
			end
			if (row_ok)
				pass_count++;
			else
				fail_count++;
			$display("%s %s", row_ok ? "ok  " : "FAIL", labels[t]);
			hold_level();
		end

		// failures from the bound checker count as well
		chk_errs = UUT.u_netcfg_regs.u_chk.err_count;
		$display("tests passed %0d failed %0d, checker errors %0d",
			pass_count, fail_count, chk_errs);
		if (fail_count == 0 && chk_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+design
design/spi_cfg_pkg.sv
design/spi_gate.sv
design/netcfg_regs.sv
design/spi_cfg_top.sv
verification/spi_cfg_chk.sv
verification/spi_cfg_tb.sv
